// File: zynq_shell_pkg.sv
package zynq_shell_pkg;

   // host bus
   localparam int AXIL_ADDR_W = 10;
   localparam int AXIL_DATA_W = 32;
   localparam int REG_WORD_W  = AXIL_ADDR_W - 2;

   // mailboxes
   localparam int FIFO_DEPTH    = 4;
   localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W    = 3;
   localparam int STAT_FIELD_W  = 8;

   // dram side
   localparam int DRAM_ADDR_W = 32;
   localparam logic [DRAM_ADDR_W-1:0] CORE_DRAM_BASE = 32'h8000_0000;
   localparam int PROF_BITS   = 128;
   localparam int REGION_W    = $clog2(PROF_BITS);
   localparam int OFFSET_W    = DRAM_ADDR_W - 2 - REGION_W;

   //////////////////////////////////////////////////////////////////////
   // register map, byte offsets
   //////////////////////////////////////////////////////////////////////
   localparam logic [AXIL_ADDR_W-1:0] REG_CTRL      = 10'h000;
   localparam logic [AXIL_ADDR_W-1:0] REG_DRAM_INIT = 10'h004;
   localparam logic [AXIL_ADDR_W-1:0] REG_DRAM_BASE = 10'h008;
   localparam logic [AXIL_ADDR_W-1:0] REG_STATUS    = 10'h00C;
   localparam logic [AXIL_ADDR_W-1:0] REG_PROF0     = 10'h010;
   localparam logic [AXIL_ADDR_W-1:0] REG_PROF1     = 10'h014;
   localparam logic [AXIL_ADDR_W-1:0] REG_PROF2     = 10'h018;
   localparam logic [AXIL_ADDR_W-1:0] REG_PROF3     = 10'h01C;
   localparam logic [AXIL_ADDR_W-1:0] REG_TX_PUSH   = 10'h020;
   localparam logic [AXIL_ADDR_W-1:0] REG_RX_POP    = 10'h024;

   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_SLVERR = 2'd2;

   typedef struct packed {
      logic                   wr;
      logic                   rd;
      logic [REG_WORD_W-1:0]  word;
      logic [AXIL_DATA_W-1:0] wdata;
   } reg_req_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0] rdata;
      logic                   err;
   } reg_rsp_t;

   // core address seen as profiler fields
   typedef struct packed {
      logic [1:0]          space;
      logic [REGION_W-1:0] region;
      logic [OFFSET_W-1:0] offset;
   } dram_addr_f_t;

   typedef union packed {
      logic [DRAM_ADDR_W-1:0] raw;
      dram_addr_f_t           f;
   } dram_addr_u;

   typedef struct packed {
      dram_addr_u addr;
      logic       we;
   } dram_req_t;

   typedef struct packed {
      logic [DRAM_ADDR_W-1:0] addr;
      logic                   we;
   } mem_req_t;

endpackage

// File: axil_slave_port.sv
`timescale 1ns/1ps

module axil_slave_port
   import zynq_shell_pkg::*;
(
   input  logic                   aclk,
   input  logic                   rst_i,
   input  logic [AXIL_ADDR_W-1:0] s_axil_awaddr_i,
   input  logic                   s_axil_awvalid_i,
   output logic                   s_axil_awready_o,
   input  logic [AXIL_DATA_W-1:0] s_axil_wdata_i,
   input  logic                   s_axil_wvalid_i,
   output logic                   s_axil_wready_o,
   output logic [1:0]             s_axil_bresp_o,
   output logic                   s_axil_bvalid_o,
   input  logic                   s_axil_bready_i,
   input  logic [AXIL_ADDR_W-1:0] s_axil_araddr_i,
   input  logic                   s_axil_arvalid_i,
   output logic                   s_axil_arready_o,
   output logic [AXIL_DATA_W-1:0] s_axil_rdata_o,
   output logic [1:0]             s_axil_rresp_o,
   output logic                   s_axil_rvalid_o,
   input  logic                   s_axil_rready_i,
   output reg_req_t               req_o,
   input  reg_rsp_t               rsp_i
);

   logic                   wr_go;
   logic                   rd_go;
   logic                   bvalid_r;
   logic                   rvalid_r;
   logic [1:0]             bresp_r;
   logic [1:0]             rresp_r;
   logic [AXIL_DATA_W-1:0] rdata_r;

   // aw and w are taken together once the b channel is free
   assign wr_go = s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_r;
   // the bank serves one access per cycle so a read yields to a write
   assign rd_go = s_axil_arvalid_i & ~rvalid_r & ~wr_go;

   assign s_axil_awready_o = wr_go;
   assign s_axil_wready_o  = wr_go;
   assign s_axil_arready_o = rd_go;

   assign req_o = '{
      wr:    wr_go,
      rd:    rd_go,
      word:  wr_go ? s_axil_awaddr_i[AXIL_ADDR_W-1:2] : s_axil_araddr_i[AXIL_ADDR_W-1:2],
      wdata: s_axil_wdata_i
   };

   //////////////////////////////////////////////////////////////////////
   // write response
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk)
   begin
      if (rst_i)
         bvalid_r <= 1'b0;
      else if (wr_go)
         bvalid_r <= 1'b1;
      else if (s_axil_bready_i)
         bvalid_r <= 1'b0;
   end

   always_ff @(posedge aclk)
   begin
      if (wr_go)
         bresp_r <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
   end

   //////////////////////////////////////////////////////////////////////
   // read response
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge aclk)
   begin
      if (rst_i)
         rvalid_r <= 1'b0;
      else if (rd_go)
         rvalid_r <= 1'b1;
      else if (s_axil_rready_i)
         rvalid_r <= 1'b0;
   end

   // data and code captured at the ar handshake
   always_ff @(posedge aclk)
   begin
      if (rd_go)
      begin
         rdata_r <= rsp_i.rdata;
         rresp_r <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
      end
   end

   assign s_axil_bvalid_o = bvalid_r;
   assign s_axil_bresp_o  = bresp_r;
   assign s_axil_rvalid_o = rvalid_r;
   assign s_axil_rresp_o  = rresp_r;
   assign s_axil_rdata_o  = rdata_r;

endmodule

// File: shell_csr_bank.sv
`timescale 1ns/1ps

module shell_csr_bank
   import zynq_shell_pkg::*;
(
   input  logic                   aclk,
   input  logic                   rst_i,
   input  reg_req_t               req_i,
   output reg_rsp_t               rsp_o,
   output logic                   run_o,
   output logic                   dram_init_o,
   output logic [DRAM_ADDR_W-1:0] dram_base_o,
   input  logic [PROF_BITS-1:0]   prof_i,
   output logic                   tx_push_o,
   output logic [AXIL_DATA_W-1:0] tx_wdata_o,
   input  logic                   tx_full_i,
   input  logic [FIFO_CNT_W-1:0]  tx_count_i,
   output logic                   rx_pop_o,
   input  logic [AXIL_DATA_W-1:0] rx_head_i,
   input  logic                   rx_empty_i,
   input  logic [FIFO_CNT_W-1:0]  rx_count_i
);

   logic [AXIL_ADDR_W-1:0] reg_addr;
   logic [AXIL_DATA_W-1:0] status_w;
   logic                   run_r;
   logic                   dram_init_r;
   logic [DRAM_ADDR_W-1:0] dram_base_r;
   logic                   ctrl_we;
   logic                   init_we;
   logic                   base_we;

   assign reg_addr = {req_i.word, 2'b00};

   // rx count low byte, tx count next byte
   assign status_w = {{(AXIL_DATA_W-2*STAT_FIELD_W){1'b0}},
                      {(STAT_FIELD_W-FIFO_CNT_W){1'b0}}, tx_count_i,
                      {(STAT_FIELD_W-FIFO_CNT_W){1'b0}}, rx_count_i};

   //////////////////////////////////////////////////////////////////////
   // decode and read mux
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      rsp_o.rdata = '0;
      rsp_o.err   = 1'b0;
      ctrl_we     = 1'b0;
      init_we     = 1'b0;
      base_we     = 1'b0;
      tx_push_o   = 1'b0;
      rx_pop_o    = 1'b0;
      case (reg_addr)
         REG_CTRL:
         begin
            rsp_o.rdata = {{(AXIL_DATA_W-1){1'b0}}, run_r};
            ctrl_we     = req_i.wr;
         end
         REG_DRAM_INIT:
         begin
            rsp_o.rdata = {{(AXIL_DATA_W-1){1'b0}}, dram_init_r};
            init_we     = req_i.wr;
         end
         REG_DRAM_BASE:
         begin
            rsp_o.rdata = dram_base_r;
            base_we     = req_i.wr;
         end
         REG_STATUS:
         begin
            rsp_o.rdata = status_w;
            rsp_o.err   = req_i.wr;
         end
         REG_PROF0, REG_PROF1, REG_PROF2, REG_PROF3:
         begin
            // word index picks the 32 bit slice, low word first
            rsp_o.rdata = prof_i[reg_addr[3:2]*AXIL_DATA_W +: AXIL_DATA_W];
            rsp_o.err   = req_i.wr;
         end
         REG_TX_PUSH:
         begin
            rsp_o.err = req_i.rd | (req_i.wr & tx_full_i);
            tx_push_o = req_i.wr & ~tx_full_i;
         end
         REG_RX_POP:
         begin
            rsp_o.rdata = rx_empty_i ? '0 : rx_head_i;
            rsp_o.err   = req_i.wr | (req_i.rd & rx_empty_i);
            rx_pop_o    = req_i.rd & ~rx_empty_i;
         end
         default:
            rsp_o.err = 1'b1;
      endcase
   end

   // control registers survive the soft reset
   always_ff @(posedge aclk)
   begin
      if (rst_i)
      begin
         run_r       <= 1'b0;
         dram_init_r <= 1'b0;
         dram_base_r <= '0;
      end
      else
      begin
         if (ctrl_we)
            run_r <= req_i.wdata[0];
         if (init_we)
            dram_init_r <= req_i.wdata[0];
         if (base_we)
            dram_base_r <= req_i.wdata;
      end
   end

   assign run_o       = run_r;
   assign dram_init_o = dram_init_r;
   assign dram_base_o = dram_base_r;
   assign tx_wdata_o  = req_i.wdata;

endmodule

// File: mailbox_fifo.sv
`timescale 1ns/1ps

module mailbox_fifo
   import zynq_shell_pkg::*;
(
   input  logic                   aclk,
   input  logic                   rst_i,
   input  logic                   push_i,
   input  logic [AXIL_DATA_W-1:0] wdata_i,
   input  logic                   pop_i,
   output logic [AXIL_DATA_W-1:0] rdata_o,
   output logic                   full_o,
   output logic                   empty_o,
   output logic [FIFO_CNT_W-1:0]  count_o
);

   logic [AXIL_DATA_W-1:0] mem_r [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0]  wr_ptr_r;
   logic [FIFO_PTR_W-1:0]  rd_ptr_r;
   logic [FIFO_CNT_W-1:0]  count_r;
   logic                   do_push;
   logic                   do_pop;

   function automatic logic [FIFO_PTR_W-1:0] ptr_next(input logic [FIFO_PTR_W-1:0] p);
      if (p == FIFO_PTR_W'(FIFO_DEPTH-1))
         return '0;
      return p + 1'b1;
   endfunction

   assign full_o  = (count_r == FIFO_CNT_W'(FIFO_DEPTH));
   assign empty_o = (count_r == '0);
   // push on full and pop on empty are dropped
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   always_ff @(posedge aclk)
   begin
      if (do_push)
         mem_r[wr_ptr_r] <= wdata_i;
   end

   always_ff @(posedge aclk)
   begin
      if (rst_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_r <= ptr_next(wr_ptr_r);
         if (do_pop)
            rd_ptr_r <= ptr_next(rd_ptr_r);
         if (do_push & ~do_pop)
            count_r <= count_r + 1'b1;
         else if (do_pop & ~do_push)
            count_r <= count_r - 1'b1;
      end
   end

   assign rdata_o = mem_r[rd_ptr_r];
   assign count_o = count_r;

endmodule

// File: dram_addr_xlate.sv
`timescale 1ns/1ps

module dram_addr_xlate
   import zynq_shell_pkg::*;
(
   input  logic                   aclk,
   input  logic                   rst_i,
   input  logic                   enable_i,
   input  logic [DRAM_ADDR_W-1:0] dram_base_i,
   input  dram_req_t              req_i,
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   output mem_req_t               mem_o,
   output logic                   mem_valid_o,
   input  logic                   mem_ready_i,
   output logic [PROF_BITS-1:0]   prof_o
);

   logic [PROF_BITS-1:0] prof_r;
   logic                 accept;

   // nothing moves until the host has allocated dram and released the core side
   assign mem_valid_o = req_valid_i & enable_i;
   assign req_ready_o = mem_ready_i & enable_i;
   assign accept      = mem_valid_o & mem_ready_i;

   //////////////////////////////////////////////////////////////////////
   // core space to host space
   //////////////////////////////////////////////////////////////////////
   // flip the top bit to strip the core dram base, then offset into the host buffer
   assign mem_o = '{
      addr: (req_i.addr.raw ^ CORE_DRAM_BASE) + dram_base_i,
      we:   req_i.we
   };

   // one sticky bit per region touched
   always_ff @(posedge aclk)
   begin
      if (rst_i)
         prof_r <= '0;
      else if (accept)
         prof_r[req_i.addr.f.region] <= 1'b1;
   end

   assign prof_o = prof_r;

endmodule

// File: zynq_shell_top.sv
`timescale 1ns/1ps

module zynq_shell_top
   import zynq_shell_pkg::*;
(
   input  logic                   aclk,
   input  logic                   rst_i,
   input  logic [AXIL_ADDR_W-1:0] s_axil_awaddr_i,
   input  logic                   s_axil_awvalid_i,
   output logic                   s_axil_awready_o,
   input  logic [AXIL_DATA_W-1:0] s_axil_wdata_i,
   input  logic                   s_axil_wvalid_i,
   output logic                   s_axil_wready_o,
   output logic [1:0]             s_axil_bresp_o,
   output logic                   s_axil_bvalid_o,
   input  logic                   s_axil_bready_i,
   input  logic [AXIL_ADDR_W-1:0] s_axil_araddr_i,
   input  logic                   s_axil_arvalid_i,
   output logic                   s_axil_arready_o,
   output logic [AXIL_DATA_W-1:0] s_axil_rdata_o,
   output logic [1:0]             s_axil_rresp_o,
   output logic                   s_axil_rvalid_o,
   input  logic                   s_axil_rready_i,
   output logic [AXIL_DATA_W-1:0] tx_data_o,
   output logic                   tx_valid_o,
   input  logic                   tx_ready_i,
   input  logic [AXIL_DATA_W-1:0] rx_data_i,
   input  logic                   rx_valid_i,
   output logic                   rx_ready_o,
   input  dram_req_t              req_i,
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   output mem_req_t               mem_o,
   output logic                   mem_valid_o,
   input  logic                   mem_ready_i
);

   reg_req_t               reg_req;
   reg_rsp_t               reg_rsp;
   logic                   run;
   logic                   dram_init;
   logic [DRAM_ADDR_W-1:0] dram_base;
   logic [PROF_BITS-1:0]   prof;
   logic                   soft_rst;
   logic                   tx_push;
   logic [AXIL_DATA_W-1:0] tx_wdata;
   logic                   tx_full;
   logic                   tx_empty;
   logic [FIFO_CNT_W-1:0]  tx_count;
   logic                   rx_pop;
   logic [AXIL_DATA_W-1:0] rx_head;
   logic                   rx_full;
   logic                   rx_empty;
   logic [FIFO_CNT_W-1:0]  rx_count;

   // run bit is active-low system reset for everything but the registers
   assign soft_rst = rst_i | ~run;

   //////////////////////////////////////////////////////////////////////
   // host register path
   //////////////////////////////////////////////////////////////////////
   axil_slave_port u_axil
   (
      .*,
      .req_o (reg_req),
      .rsp_i (reg_rsp)
   );

   shell_csr_bank u_csr
   (
      .aclk        (aclk),
      .rst_i       (rst_i),
      .req_i       (reg_req),
      .rsp_o       (reg_rsp),
      .run_o       (run),
      .dram_init_o (dram_init),
      .dram_base_o (dram_base),
      .prof_i      (prof),
      .tx_push_o   (tx_push),
      .tx_wdata_o  (tx_wdata),
      .tx_full_i   (tx_full),
      .tx_count_i  (tx_count),
      .rx_pop_o    (rx_pop),
      .rx_head_i   (rx_head),
      .rx_empty_i  (rx_empty),
      .rx_count_i  (rx_count)
   );

   //////////////////////////////////////////////////////////////////////
   // mailboxes
   //////////////////////////////////////////////////////////////////////
   assign tx_valid_o = ~tx_empty;
   assign rx_ready_o = ~rx_full;

   mailbox_fifo u_tx_fifo
   (
      .aclk    (aclk),
      .rst_i   (soft_rst),
      .push_i  (tx_push),
      .wdata_i (tx_wdata),
      .pop_i   (tx_valid_o & tx_ready_i),
      .rdata_o (tx_data_o),
      .full_o  (tx_full),
      .empty_o (tx_empty),
      .count_o (tx_count)
   );

   mailbox_fifo u_rx_fifo
   (
      .aclk    (aclk),
      .rst_i   (soft_rst),
      .push_i  (rx_valid_i & rx_ready_o),
      .wdata_i (rx_data_i),
      .pop_i   (rx_pop),
      .rdata_o (rx_head),
      .full_o  (rx_full),
      .empty_o (rx_empty),
      .count_o (rx_count)
   );

   // dram requests pass only once the host buffer exists
   dram_addr_xlate u_xlate
   (
      .aclk        (aclk),
      .rst_i       (soft_rst),
      .enable_i    (dram_init & run),
      .dram_base_i (dram_base),
      .req_i       (req_i),
      .req_valid_i (req_valid_i),
      .req_ready_o (req_ready_o),
      .mem_o       (mem_o),
      .mem_valid_o (mem_valid_o),
      .mem_ready_i (mem_ready_i),
      .prof_o      (prof)
   );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
(
   output logic clk_o,
   output logic rst_o
);

   // 100 ns period
   initial
   begin
      clk_o = 1'b0;
      forever
         #50 clk_o = ~clk_o;
   end

   // reset held for the first 10 rising edges
   initial
   begin
      rst_o = 1'b1;
      repeat (10) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

// File: tb_zynq_shell.sv
`timescale 1ns/1ps

module tb_zynq_shell
   import zynq_shell_pkg::*;
;

   localparam int NUM_ACCESSES    = 64;
   localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 20 + 2000;

   logic                   clk;
   logic                   rst;
   logic                   rst_q = 1'b0;
   logic [AXIL_ADDR_W-1:0] awaddr;
   logic                   awvalid;
   logic                   awready;
   logic [AXIL_DATA_W-1:0] wdata;
   logic                   wvalid;
   logic                   wready;
   logic [1:0]             bresp;
   logic                   bvalid;
   logic                   bready;
   logic [AXIL_ADDR_W-1:0] araddr;
   logic                   arvalid;
   logic                   arready;
   logic [AXIL_DATA_W-1:0] rdata;
   logic [1:0]             rresp;
   logic                   rvalid;
   logic                   rready;
   logic [AXIL_DATA_W-1:0] tx_data;
   logic                   tx_valid;
   logic                   tx_ready;
   logic [AXIL_DATA_W-1:0] rx_data;
   logic                   rx_valid;
   logic                   rx_ready;
   dram_req_t              req;
   logic                   req_valid;
   logic                   req_ready;
   mem_req_t               mem;
   logic                   mem_valid;
   logic                   mem_ready;
   logic [31:0]            lfsr_q = 32'd84774;
   logic [31:0]            exp_q [$];

   tb_clk_gen u_clk
   (
      .clk_o (clk),
      .rst_o (rst)
   );

   zynq_shell_top u_dut
   (
      .aclk             (clk),
      .rst_i            (rst),
      .s_axil_awaddr_i  (awaddr),
      .s_axil_awvalid_i (awvalid),
      .s_axil_awready_o (awready),
      .s_axil_wdata_i   (wdata),
      .s_axil_wvalid_i  (wvalid),
      .s_axil_wready_o  (wready),
      .s_axil_bresp_o   (bresp),
      .s_axil_bvalid_o  (bvalid),
      .s_axil_bready_i  (bready),
      .s_axil_araddr_i  (araddr),
      .s_axil_arvalid_i (arvalid),
      .s_axil_arready_o (arready),
      .s_axil_rdata_o   (rdata),
      .s_axil_rresp_o   (rresp),
      .s_axil_rvalid_o  (rvalid),
      .s_axil_rready_i  (rready),
      .tx_data_o        (tx_data),
      .tx_valid_o       (tx_valid),
      .tx_ready_i       (tx_ready),
      .rx_data_i        (rx_data),
      .rx_valid_i       (rx_valid),
      .rx_ready_o       (rx_ready),
      .req_i            (req),
      .req_valid_i      (req_valid),
      .req_ready_o      (req_ready),
      .mem_o            (mem),
      .mem_valid_o      (mem_valid),
      .mem_ready_i      (mem_ready)
   );

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////
   task automatic abort_run();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Error at %0t ns: %s expected 0x%08h, actual 0x%08h", $time, name, exp, got);
         abort_run();
      end
   endtask

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   // all bus tasks start and end on a rising edge
   task automatic write_expect(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                               input logic [1:0] exp_resp);
      awaddr  <= addr;
      wdata   <= data;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      do
         @(posedge clk);
      while (!awready);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do
         @(posedge clk);
      while (!bvalid);
      check_eq("s_axil_bresp_o", bresp, exp_resp);
   endtask

   task automatic read_expect(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] exp_data,
                              input logic [1:0] exp_resp);
      araddr  <= addr;
      arvalid <= 1'b1;
      do
         @(posedge clk);
      while (!arready);
      arvalid <= 1'b0;
      do
         @(posedge clk);
      while (!rvalid);
      check_eq("s_axil_rresp_o", rresp, exp_resp);
      check_eq("s_axil_rdata_o", rdata, exp_data);
   endtask

   //////////////////////////////////////////////////////////////////////
   // protocol checks
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
      rst_q <= rst;

   assert property (@(posedge clk) rst_q |-> !(bvalid || rvalid || tx_valid || mem_valid))
   else
   begin
      $display("Error at %0t ns: a response or stream valid was high during reset", $time);
      abort_run();
   end

   // aw and w accepted together, only while both are offered and b is free
   assert property (@(posedge clk) disable iff (rst)
                    (awready || wready) |-> (awready && wready && awvalid && wvalid && !bvalid))
   else
   begin
      $display("Error at %0t ns: awready and wready did not rise together on a write", $time);
      abort_run();
   end

   assert property (@(posedge clk) disable iff (rst) (awvalid && awready) |=> $rose(bvalid))
   else
   begin
      $display("Error at %0t ns: bvalid did not rise one cycle after the write", $time);
      abort_run();
   end

   assert property (@(posedge clk) disable iff (rst) (arvalid && arready) |=> $rose(rvalid))
   else
   begin
      $display("Error at %0t ns: rvalid did not rise one cycle after the read", $time);
      abort_run();
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
      abort_run();
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      logic [31:0]          w;
      logic [31:0]          a;
      logic [31:0]          we;
      logic [31:0]          base;
      logic [PROF_BITS-1:0] prof_exp;
      int                   n;

      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wvalid    = 1'b0;
      bready    = 1'b1;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b1;
      tx_ready  = 1'b0;
      rx_data   = '0;
      rx_valid  = 1'b0;
      req       = '0;
      // a request waits through reset so the dram gate is probed
      req_valid = 1'b1;
      mem_ready = 1'b0;
      prof_exp  = '0;
      do
         @(posedge clk);
      while (rst);
      req_valid <= 1'b0;

      // every mapped register starts at zero
      for (int i = 0; i < 8; i++)
         read_expect(AXIL_ADDR_W'(i * 4), 32'd0, RESP_OKAY);
      take_bits(32, w);
      write_expect(REG_CTRL, w | 32'd1, RESP_OKAY);
      read_expect(REG_CTRL, 32'd1, RESP_OKAY);
      take_bits(32, base);
      write_expect(REG_DRAM_BASE, base, RESP_OKAY);
      read_expect(REG_DRAM_BASE, base, RESP_OKAY);

      // error responses
      read_expect(10'h3FC, 32'd0, RESP_SLVERR);
      write_expect(10'h028, w, RESP_SLVERR);
      write_expect(REG_STATUS, w, RESP_SLVERR);
      read_expect(REG_TX_PUSH, 32'd0, RESP_SLVERR);

      // tx mailbox fills, then drains in order
      for (int i = 0; i < FIFO_DEPTH; i++)
      begin
         take_bits(32, w);
         exp_q.push_back(w);
         write_expect(REG_TX_PUSH, w, RESP_OKAY);
      end
      take_bits(32, w);
      write_expect(REG_TX_PUSH, w, RESP_SLVERR);
      read_expect(REG_STATUS, 32'h0000_0400, RESP_OKAY);
      tx_ready <= 1'b1;
      for (int i = 0; i < FIFO_DEPTH; i++)
      begin
         do
            @(posedge clk);
         while (!(tx_valid && tx_ready));
         check_eq("tx_data_o", tx_data, exp_q.pop_front());
      end
      tx_ready <= 1'b0;

      // rx mailbox fills from the stream until ready drops
      take_bits(32, w);
      rx_data  <= w;
      rx_valid <= 1'b1;
      n = 0;
      while (n < FIFO_DEPTH)
      begin
         @(posedge clk);
         if (rx_ready)
         begin
            exp_q.push_back(rx_data);
            n++;
            take_bits(32, w);
            rx_data <= w;
         end
      end
      @(posedge clk);
      check_eq("rx_ready_o", rx_ready, 32'd0);
      rx_valid <= 1'b0;
      for (int i = 0; i < FIFO_DEPTH; i++)
         read_expect(REG_RX_POP, exp_q.pop_front(), RESP_OKAY);
      read_expect(REG_RX_POP, 32'd0, RESP_SLVERR);

      // dram path held off while the flag is clear
      take_bits(32, a);
      req       <= {a, 1'b1};
      req_valid <= 1'b1;
      mem_ready <= 1'b1;
      @(posedge clk);
      check_eq("mem_valid_o", mem_valid, 32'd0);
      check_eq("req_ready_o", req_ready, 32'd0);
      req_valid <= 1'b0;
      write_expect(REG_DRAM_INIT, 32'd1, RESP_OKAY);
      read_expect(REG_DRAM_INIT, 32'd1, RESP_OKAY);
      for (int i = 0; i < 6; i++)
      begin
         take_bits(32, a);
         take_bits(1, we);
         req       <= {a, we[0]};
         req_valid <= 1'b1;
         @(posedge clk);
         check_eq("mem_valid_o", mem_valid, 32'd1);
         check_eq("req_ready_o", req_ready, 32'd1);
         check_eq("mem_o.addr", mem.addr, (a ^ 32'h8000_0000) + base);
         check_eq("mem_o.we", mem.we, we);
         // region is bits 29:23 of the core address
         prof_exp[a[29:23]] = 1'b1;
      end
      req_valid <= 1'b0;
      for (int i = 0; i < 4; i++)
         read_expect(REG_PROF0 + AXIL_ADDR_W'(i * 4), prof_exp[i*32 +: 32], RESP_OKAY);

      // soft reset through the run bit
      take_bits(32, w);
      write_expect(REG_TX_PUSH, w, RESP_OKAY);
      take_bits(32, w);
      write_expect(REG_TX_PUSH, w, RESP_OKAY);
      take_bits(32, w);
      rx_data  <= w;
      rx_valid <= 1'b1;
      do
         @(posedge clk);
      while (!rx_ready);
      rx_valid <= 1'b0;
      read_expect(REG_STATUS, 32'h0000_0201, RESP_OKAY);
      write_expect(REG_CTRL, 32'd0, RESP_OKAY);
      write_expect(REG_CTRL, 32'd1, RESP_OKAY);
      @(posedge clk);
      check_eq("tx_valid_o", tx_valid, 32'd0);
      read_expect(REG_STATUS, 32'd0, RESP_OKAY);
      for (int i = 0; i < 4; i++)
         read_expect(REG_PROF0 + AXIL_ADDR_W'(i * 4), 32'd0, RESP_OKAY);
      read_expect(REG_DRAM_BASE, base, RESP_OKAY);

      $display("sim passed");
      $finish;
   end

endmodule

// File: all.f
zynq_shell_pkg.sv
axil_slave_port.sv
shell_csr_bank.sv
mailbox_fifo.sv
dram_addr_xlate.sv
zynq_shell_top.sv
tb_clk_gen.sv
tb_zynq_shell.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_zynq_shell \
   -f all.f
./obj_dir/Vtb_zynq_shell
